// ==== adc_lvds_pkg.sv ====
package adc_lvds_pkg;

	// Eight data lanes, two per channel, plus the frame lane.
	localparam int NUM_LANES = 9;
	localparam int FRAME_LANE = 8; // The frame lane sits above the data lanes.

	localparam int WORD_BITS = 8;
	localparam int SAMPLE_BITS = 2 * WORD_BITS; // Each sample comes from one lane pair.
	localparam int TAP_BITS = 5;

	typedef logic [WORD_BITS-1:0] lane_word_t;
	typedef logic [SAMPLE_BITS-1:0] sample_t;
	typedef logic [TAP_BITS-1:0] tap_t;

	// The converter drives this word on the frame lane at every sample boundary.
	localparam lane_word_t FRAME_PATTERN = 8'hF0;

endpackage

// ==== lane_delay.sv ====
`timescale 1ns/1ps

module lane_delay (
	input  logic                                             dco_clk,
	input  logic                                             rst_n,
	input  logic [adc_lvds_pkg::NUM_LANES-1:0]               lane_in,
	input  adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] value_in,
	input  logic [adc_lvds_pkg::NUM_LANES-1:0]               ld,
	input  logic [adc_lvds_pkg::NUM_LANES-1:0]               ce,
	output adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] value_out,
	output logic [adc_lvds_pkg::NUM_LANES-1:0]               lane_out
);

	localparam int DEPTH = 2 ** $bits(adc_lvds_pkg::tap_t);

	logic [adc_lvds_pkg::NUM_LANES-1:0] ld_meta, ld_sync, ld_prev;
	logic [adc_lvds_pkg::NUM_LANES-1:0] ce_meta, ce_sync, ce_prev;
	logic [adc_lvds_pkg::NUM_LANES-1:0] ld_pulse, ce_pulse;
	adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] tap;
	logic [DEPTH-1:0] hist [adc_lvds_pkg::NUM_LANES];

	// Control levels come from a slow host, so they pass two flops first.
	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_meta <= '0;
			ld_sync <= '0;
			ld_prev <= '0;
			ce_meta <= '0;
			ce_sync <= '0;
			ce_prev <= '0;
		end else begin
			ld_meta <= ld;
			ld_sync <= ld_meta;
			ld_prev <= ld_sync;
			ce_meta <= ce;
			ce_sync <= ce_meta;
			ce_prev <= ce_sync;
		end
	end

	assign ld_pulse = ld_sync & ~ld_prev;
	assign ce_pulse = ce_sync & ~ce_prev;

	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n) begin
			tap <= '0;
		end else begin
			for (int i = 0; i < adc_lvds_pkg::NUM_LANES; i++) begin
				if (ld_pulse[i])
					tap[i] <= value_in[i];
				else if (ce_pulse[i])
					tap[i] <= tap[i] + 1'b1; // Wraps from 31 back to 0.
			end
		end
	end

	always_ff @(posedge dco_clk) begin
		for (int i = 0; i < adc_lvds_pkg::NUM_LANES; i++)
			hist[i] <= {hist[i][DEPTH-2:0], lane_in[i]};
	end

	// Stage 0 already holds last cycle's bit, so tap n gives n + 1 cycles.
	always_comb begin
		for (int i = 0; i < adc_lvds_pkg::NUM_LANES; i++)
			lane_out[i] = hist[i][tap[i]];
	end

	assign value_out = tap;

	a_ld_ce_exclusive: assert property (@(posedge dco_clk) disable iff (!rst_n)
		(ld_pulse & ce_pulse) == '0)
		else $error("lane_delay: load and increment hit the same lane together");

endmodule

// ==== lane_deser.sv ====
`timescale 1ns/1ps

module lane_deser #(
	parameter logic [7:0] FLIP_D     = 8'h00,
	parameter logic       FLIP_FRAME = 1'b0
) (
	input  logic                                                   dco_clk,
	input  logic                                                   rst_n,
	input  logic [adc_lvds_pkg::NUM_LANES-1:0]                     lane_in,
	input  logic                                                   bitslip,
	output logic                                                   word_stb,
	output adc_lvds_pkg::lane_word_t [adc_lvds_pkg::NUM_LANES-1:0] lane_words
);

	localparam int WB = adc_lvds_pkg::WORD_BITS;
	localparam int CNT_BITS = $clog2(WB);
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(WB - 1);
	localparam logic [adc_lvds_pkg::NUM_LANES-1:0] FLIP = {FLIP_FRAME, FLIP_D};

	logic [adc_lvds_pkg::NUM_LANES-1:0] lane_bit;
	logic [adc_lvds_pkg::NUM_LANES-1:0][WB-2:0] shift;
	logic [CNT_BITS-1:0] bit_cnt;
	logic word_done;

	assign lane_bit = lane_in ^ FLIP; // Undo the swapped pairs on the board.

	// A slip holds the count, so the next word ends one bit later.
	assign word_done = (bit_cnt == CNT_LAST) && !bitslip;

	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			word_stb <= 1'b0;
		end else begin
			word_stb <= word_done;
			if (!bitslip)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// The first bit in lands in the top of the word.
	always_ff @(posedge dco_clk) begin
		for (int i = 0; i < adc_lvds_pkg::NUM_LANES; i++) begin
			shift[i] <= {shift[i][WB-3:0], lane_bit[i]};
			if (word_done)
				lane_words[i] <= {shift[i], lane_bit[i]};
		end
	end

	a_stb_single: assert property (@(posedge dco_clk) disable iff (!rst_n)
		word_stb |=> !word_stb)
		else $error("lane_deser: word_stb held for two cycles");

endmodule

// ==== frame_align.sv ====
`timescale 1ns/1ps

module frame_align #(
	parameter int SLIP_SETTLE = 2
) (
	input  logic                     dco_clk,
	input  logic                     rst_n,
	input  logic                     word_stb,
	input  adc_lvds_pkg::lane_word_t frame_word,
	input  logic                     align_restart,
	output logic                     bitslip,
	output logic                     aligned
);

	typedef enum logic [2:0] {
		HUNT,
		SLIP,
		SETTLE,
		CONFIRM,
		LOCKED
	} align_state_t;

	localparam int CNT_BITS = $clog2(SLIP_SETTLE + 2);

	align_state_t state, state_next;
	logic [CNT_BITS-1:0] settle_cnt;
	logic frame_ok;

	assign frame_ok = (frame_word == adc_lvds_pkg::FRAME_PATTERN);

	always_comb begin
		state_next = state;
		case (state)
			HUNT: begin
				if (word_stb)
					state_next = frame_ok ? CONFIRM : SLIP;
			end
			SLIP: begin
				state_next = (SLIP_SETTLE > 0) ? SETTLE : HUNT;
			end
			SETTLE: begin
				// Words seen here may still straddle the old boundary.
				if (word_stb && settle_cnt == CNT_BITS'(1))
					state_next = HUNT;
			end
			CONFIRM: begin
				if (word_stb)
					state_next = frame_ok ? LOCKED : SLIP;
			end
			LOCKED: begin
				state_next = LOCKED; // Frame errors are ignored once locked.
			end
			default: begin
				state_next = HUNT;
			end
		endcase
		if (align_restart)
			state_next = HUNT;
	end

	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n)
			state <= HUNT;
		else
			state <= state_next;
	end

	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n)
			settle_cnt <= '0;
		else if (state == SLIP)
			settle_cnt <= CNT_BITS'(SLIP_SETTLE);
		else if (state == SETTLE && word_stb)
			settle_cnt <= settle_cnt - 1'b1;
	end

	assign bitslip = (state == SLIP);
	assign aligned = (state == LOCKED);

	a_slip_pulse: assert property (@(posedge dco_clk) disable iff (!rst_n)
		bitslip |=> !bitslip)
		else $error("frame_align: bitslip longer than one cycle");

	// Lock holds off slips until the host asks for a new search.
	a_no_slip_locked: assert property (@(posedge dco_clk) disable iff (!rst_n)
		aligned && !align_restart |=> !bitslip)
		else $error("frame_align: bitslip issued while locked");

endmodule

// ==== sample_pack.sv ====
`timescale 1ns/1ps

module sample_pack (
	input  logic                                 dco_clk,
	input  logic                                 rst_n,
	input  logic                                 word_stb,
	input  logic                                 aligned,
	input  adc_lvds_pkg::lane_word_t [7:0]       data_words,
	output logic                                 sample_valid,
	output adc_lvds_pkg::sample_t                ch_a,
	output adc_lvds_pkg::sample_t                ch_b,
	output adc_lvds_pkg::sample_t                ch_c,
	output adc_lvds_pkg::sample_t                ch_d
);

	// D1 carries the odd sample bits and D0 the even ones.
	function automatic adc_lvds_pkg::sample_t interleave(
		input adc_lvds_pkg::lane_word_t d1,
		input adc_lvds_pkg::lane_word_t d0
	);
		adc_lvds_pkg::sample_t s;
		for (int j = 0; j < adc_lvds_pkg::WORD_BITS; j++) begin
			s[2*j+1] = d1[j];
			s[2*j] = d0[j];
		end
		return s;
	endfunction

	logic take;

	assign take = word_stb && aligned;

	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_valid <= 1'b0;
			ch_a <= '0;
			ch_b <= '0;
			ch_c <= '0;
			ch_d <= '0;
		end else begin
			sample_valid <= take;
			if (take) begin
				ch_a <= interleave(data_words[7], data_words[6]);
				ch_b <= interleave(data_words[5], data_words[4]);
				ch_c <= interleave(data_words[3], data_words[2]);
				ch_d <= interleave(data_words[1], data_words[0]);
			end
		end
	end

	a_valid_aligned: assert property (@(posedge dco_clk) disable iff (!rst_n)
		sample_valid |-> $past(aligned))
		else $error("sample_pack: sample_valid without alignment");

endmodule

// ==== adc_lvds_rx.sv ====
`timescale 1ns/1ps

module adc_lvds_rx #(
	parameter logic [7:0] FLIP_D      = 8'h00,
	parameter logic       FLIP_FRAME  = 1'b0,
	parameter int         SLIP_SETTLE = 2
) (
	input  logic                                             dco_clk,
	input  logic                                             rst_n,
	input  logic [7:0]                                       d,
	input  logic                                             frame,
	input  adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] delay_value_in,
	input  logic [adc_lvds_pkg::NUM_LANES-1:0]               delay_ld,
	input  logic [adc_lvds_pkg::NUM_LANES-1:0]               delay_ce,
	input  logic                                             align_restart,
	output adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] delay_value_out,
	output logic                                             aligned,
	output logic                                             sample_valid,
	output adc_lvds_pkg::sample_t                            ch_a,
	output adc_lvds_pkg::sample_t                            ch_b,
	output adc_lvds_pkg::sample_t                            ch_c,
	output adc_lvds_pkg::sample_t                            ch_d
);

	logic [adc_lvds_pkg::NUM_LANES-1:0] lanes_raw;
	logic [adc_lvds_pkg::NUM_LANES-1:0] lanes_dly;
	adc_lvds_pkg::lane_word_t [adc_lvds_pkg::NUM_LANES-1:0] lane_words;
	logic word_stb;
	logic bitslip;
	logic restart_q1, restart_q2, restart_pulse;

	assign lanes_raw[adc_lvds_pkg::FRAME_LANE] = frame;
	assign lanes_raw[adc_lvds_pkg::FRAME_LANE-1:0] = d;

	always_ff @(posedge dco_clk or negedge rst_n) begin
		if (!rst_n) begin
			restart_q1 <= 1'b0;
			restart_q2 <= 1'b0;
		end else begin
			restart_q1 <= align_restart;
			restart_q2 <= restart_q1;
		end
	end

	assign restart_pulse = restart_q1 & ~restart_q2; // One search per rising edge.

	lane_delay i_lane_delay (
		.dco_clk   (dco_clk),
		.rst_n     (rst_n),
		.lane_in   (lanes_raw),
		.value_in  (delay_value_in),
		.ld        (delay_ld),
		.ce        (delay_ce),
		.value_out (delay_value_out),
		.lane_out  (lanes_dly)
	);

	lane_deser #(.FLIP_D(FLIP_D), .FLIP_FRAME(FLIP_FRAME)) i_lane_deser (
		.dco_clk    (dco_clk),
		.rst_n      (rst_n),
		.lane_in    (lanes_dly),
		.bitslip    (bitslip),
		.word_stb   (word_stb),
		.lane_words (lane_words)
	);

	frame_align #(.SLIP_SETTLE(SLIP_SETTLE)) i_frame_align (
		.dco_clk       (dco_clk),
		.rst_n         (rst_n),
		.word_stb      (word_stb),
		.frame_word    (lane_words[adc_lvds_pkg::FRAME_LANE]),
		.align_restart (restart_pulse),
		.bitslip       (bitslip),
		.aligned       (aligned)
	);

	sample_pack i_sample_pack (
		.dco_clk      (dco_clk),
		.rst_n        (rst_n),
		.word_stb     (word_stb),
		.aligned      (aligned),
		.data_words   (lane_words[adc_lvds_pkg::FRAME_LANE-1:0]),
		.sample_valid (sample_valid),
		.ch_a         (ch_a),
		.ch_b         (ch_b),
		.ch_c         (ch_c),
		.ch_d         (ch_d)
	);

endmodule

// ==== tb_adc_lvds_rx.sv ====
`timescale 1ns/1ps

module tb_adc_lvds_rx;

	localparam logic [7:0] FLIP_D = 8'h5A;
	localparam logic FLIP_FRAME = 1'b1;
	localparam int SLIP_SETTLE = 2;
	// Eight slips, each followed by its settle strobes, then the two confirming words.
	localparam int ALIGN_CYCLES = (8 * (SLIP_SETTLE + 1) + 4) * adc_lvds_pkg::WORD_BITS;
	localparam int REALIGN_CYCLES = 12 * adc_lvds_pkg::WORD_BITS; // The boundary is kept.
	localparam int NUM_SAMPLES = 1024;

	logic dco_clk;
	logic rst_n;
	logic [7:0] d;
	logic frame;
	adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] delay_value_in;
	logic [adc_lvds_pkg::NUM_LANES-1:0] delay_ld;
	logic [adc_lvds_pkg::NUM_LANES-1:0] delay_ce;
	logic align_restart;
	adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] delay_value_out;
	logic aligned;
	logic sample_valid;
	adc_lvds_pkg::sample_t ch_a, ch_b, ch_c, ch_d;

	logic [63:0] model_q[$]; // One entry per sample period, channel A in the top bits.
	adc_lvds_pkg::tap_t [adc_lvds_pkg::NUM_LANES-1:0] tap_model;
	int skew [adc_lvds_pkg::NUM_LANES];
	int start_phase;
	int bit_pos;
	int next_idx;
	logic corrupt_on;
	logic [31:0] corrupt_bits;
	logic watch_lock;
	int error_count;
	int test_errors;
	int tests_run;
	int tests_failed;

	adc_lvds_rx #(
		.FLIP_D      (FLIP_D),
		.FLIP_FRAME  (FLIP_FRAME),
		.SLIP_SETTLE (SLIP_SETTLE)
	) i_adc_lvds_rx (
		.dco_clk         (dco_clk),
		.rst_n           (rst_n),
		.d               (d),
		.frame           (frame),
		.delay_value_in  (delay_value_in),
		.delay_ld        (delay_ld),
		.delay_ce        (delay_ce),
		.align_restart   (align_restart),
		.delay_value_out (delay_value_out),
		.aligned         (aligned),
		.sample_valid    (sample_valid),
		.ch_a            (ch_a),
		.ch_b            (ch_b),
		.ch_c            (ch_c),
		.ch_d            (ch_d)
	);

	initial begin
		dco_clk = 1'b0;
		forever #50 dco_clk = ~dco_clk;
	end

	// Bit k of a sample period on one lane, as the converter puts it on the wire.
	function automatic logic stream_bit(input int lane, input int pos);
		logic [63:0] word;
		logic [15:0] smp;
		logic b;
		int idx;
		int k;
		idx = pos / 8;
		k = pos % 8;
		if (lane == adc_lvds_pkg::FRAME_LANE) begin
			b = adc_lvds_pkg::FRAME_PATTERN[7 - k] ^ FLIP_FRAME;
		end else begin
			word = (idx < model_q.size()) ? model_q[idx] : '0;
			smp = word[16 * (lane / 2) +: 16];
			b = (lane % 2 == 1) ? smp[15 - 2 * k] : smp[14 - 2 * k]; // D1 odd, D0 even.
			b = b ^ FLIP_D[lane];
		end
		return b;
	endfunction

	initial begin
		logic [adc_lvds_pkg::NUM_LANES-1:0] lane_bits;
		d = '0;
		frame = 1'b0;
		@(negedge dco_clk);
		bit_pos = start_phase;
		forever begin
			// A skewed lane runs ahead of the others.
			for (int l = 0; l < adc_lvds_pkg::NUM_LANES; l++)
				lane_bits[l] = stream_bit(l, bit_pos + skew[l]);
			if (corrupt_on)
				lane_bits[adc_lvds_pkg::FRAME_LANE] ^= corrupt_bits[bit_pos % 32];
			d = lane_bits[7:0];
			frame = lane_bits[adc_lvds_pkg::FRAME_LANE];
			bit_pos++;
			@(negedge dco_clk);
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, want);
			error_count++;
		end
	endtask

	always @(negedge dco_clk) begin
		if (watch_lock)
			check_value("aligned", 32'(aligned), 32'd1);
	end

	task automatic end_test(input string name);
		if (error_count == test_errors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, error_count - test_errors);
			tests_failed++;
		end
		tests_run++;
		test_errors = error_count;
	endtask

	task automatic check_idle();
		check_value("aligned", 32'(aligned), 32'd0);
		check_value("sample_valid", 32'(sample_valid), 32'd0);
		check_value("ch_a", 32'(ch_a), 32'd0);
		check_value("ch_b", 32'(ch_b), 32'd0);
		check_value("ch_c", 32'(ch_c), 32'd0);
		check_value("ch_d", 32'(ch_d), 32'd0);
		for (int i = 0; i < adc_lvds_pkg::NUM_LANES; i++)
			check_value($sformatf("delay_value_out[%0d]", i), 32'(delay_value_out[i]), 32'd0);
	endtask

	task automatic wait_aligned(input int limit);
		int n;
		n = 0;
		while (!aligned && n < limit) begin
			@(negedge dco_clk);
			n++;
		end
		if (!aligned) begin
			$display("timeout: aligned did not rise within %0d cycles", limit);
			error_count++;
		end
	endtask

	task automatic wait_valid(output bit ok);
		int n;
		n = 0;
		do begin
			@(negedge dco_clk);
			n++;
		end while (!sample_valid && n < 16);
		ok = sample_valid;
		if (!ok) begin
			$display("timeout: no sample_valid within 16 cycles at %0t", $time);
			error_count++;
		end
	endtask

	function automatic int find_sample();
		for (int i = 0; i < model_q.size(); i++)
			if (model_q[i] == {ch_a, ch_b, ch_c, ch_d})
				return i;
		return -1;
	endfunction

	task automatic sync_samples();
		int tries;
		int found;
		bit ok;
		found = -1;
		tries = 0;
		while (found < 0 && tries < 4) begin
			wait_valid(ok);
			if (!ok)
				break;
			found = find_sample();
			tries++;
		end
		if (found < 0) begin
			$display("no output sample matched the model stream at %0t", $time);
			error_count++;
		end else begin
			next_idx = found + 1;
		end
	endtask

	task automatic check_samples(input int count);
		bit ok;
		logic [63:0] want;
		for (int i = 0; i < count; i++) begin
			wait_valid(ok);
			if (!ok)
				break;
			if (next_idx >= model_q.size()) begin
				$display("the model ran out of samples at %0t", $time);
				error_count++;
				break;
			end
			want = model_q[next_idx];
			check_value("ch_a", 32'(ch_a), 32'(want[63:48]));
			check_value("ch_b", 32'(ch_b), 32'(want[47:32]));
			check_value("ch_c", 32'(ch_c), 32'(want[31:16]));
			check_value("ch_d", 32'(ch_d), 32'(want[15:0]));
			next_idx++;
		end
	endtask

	task automatic wait_taps();
		int n;
		n = 0;
		while (delay_value_out != tap_model && n < 8) begin
			@(negedge dco_clk);
			n++;
		end
		for (int i = 0; i < adc_lvds_pkg::NUM_LANES; i++)
			check_value($sformatf("delay_value_out[%0d]", i), 32'(delay_value_out[i]),
				32'(tap_model[i]));
	endtask

	task automatic load_taps();
		delay_value_in = tap_model;
		delay_ld = '1;
		wait_taps();
		delay_ld = '0;
	endtask

	task automatic bump_tap(input int lane);
		tap_model[lane] = tap_model[lane] + 1'b1;
		delay_ce[lane] = 1'b1;
		wait_taps();
		delay_ce = '0;
	endtask

	task automatic restart_align();
		int n;
		align_restart = 1'b1;
		n = 0;
		while (aligned && n < 2) begin
			@(negedge dco_clk);
			n++;
		end
		check_value("aligned", 32'(aligned), 32'd0);
		@(negedge dco_clk);
		align_restart = 1'b0;
	endtask

	task automatic realign_and_check(input int count);
		restart_align();
		wait_aligned(REALIGN_CYCLES);
		sync_samples();
		check_samples(count);
	endtask

	initial begin
		int unsigned seed_ret;
		int lane;
		int s;
		seed_ret = $urandom(32'h3d13_302e);
		rst_n = 1'b0;
		delay_value_in = '0;
		delay_ld = '0;
		delay_ce = '0;
		align_restart = 1'b0;
		tap_model = '0;
		corrupt_on = 1'b0;
		corrupt_bits = '0;
		watch_lock = 1'b0;
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		next_idx = 0;
		foreach (skew[i])
			skew[i] = 0;
		for (int i = 0; i < NUM_SAMPLES; i++)
			model_q.push_back({$urandom, $urandom});
		start_phase = int'($urandom % 8);

		for (int c = 0; c < 8; c++) begin
			@(negedge dco_clk);
			check_idle();
		end
		rst_n = 1'b1;
		for (int c = 0; c < 4; c++) begin
			@(negedge dco_clk);
			check_idle();
		end
		end_test("reset");

		wait_aligned(ALIGN_CYCLES);
		end_test("initial alignment");

		sync_samples();
		check_samples(64);
		end_test("sample stream");

		lane = int'($urandom % adc_lvds_pkg::NUM_LANES);
		s = 1 + int'($urandom % 6);
		$display("lane %0d runs %0d bits ahead", lane, s);
		skew[lane] = s;
		tap_model = '0;
		tap_model[lane] = adc_lvds_pkg::tap_t'(s);
		load_taps();
		realign_and_check(32);
		tap_model[lane] = adc_lvds_pkg::tap_t'(s - 1);
		load_taps();
		bump_tap(lane);
		realign_and_check(32);
		end_test("lane skew");

		realign_and_check(16);
		end_test("restart");

		corrupt_bits = $urandom | 32'h1;
		watch_lock = 1'b1;
		corrupt_on = 1'b1;
		check_samples(24);
		corrupt_on = 1'b0;
		check_samples(8);
		watch_lock = 1'b0;
		end_test("frame corruption");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== adc_lvds_rx.f ====
adc_lvds_pkg.sv
lane_delay.sv
lane_deser.sv
frame_align.sv
sample_pack.sv
adc_lvds_rx.sv
tb_adc_lvds_rx.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_adc_lvds_rx
RTL_TOP   := adc_lvds_rx
FILELIST  := adc_lvds_rx.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
